//--- oflow_pkg.sv
// shared widths, box and weight structs, history entry and PE result types
`default_nettype none

package oflow_pkg;

	// ------------------------------
	// widths
	// ------------------------------
	localparam int COORD_LEN            = 8;   // every box field
	localparam int WEIGHT_LEN           = 4;   // every weight
	localparam int SCORE_LEN            = 16;  // six weighted abs diffs fit here
	localparam int ID_LEN               = 8;   // id 0 = none
	localparam int MAX_BBOXES_PER_FRAME = 32;  // depth of one history bank
	localparam int BBOX_CNT_LEN         = 6;   // frame / set box counts
	localparam int FRAME_NUM_LEN        = 8;
	localparam int ADDR_LEN             = $clog2(MAX_BBOXES_PER_FRAME); // bank address

	// ------------------------------
	// types
	// ------------------------------
	typedef logic [ID_LEN-1:0] id_t;

	// one box as delivered by the dma, 48 bits
	typedef struct packed {
		logic [COORD_LEN-1:0] x;
		logic [COORD_LEN-1:0] y;
		logic [COORD_LEN-1:0] w;
		logic [COORD_LEN-1:0] h;
		logic [COORD_LEN-1:0] color1;
		logic [COORD_LEN-1:0] color2;
	} bbox_t;

	// register file weights, pos weights both x and y
	typedef struct packed {
		logic [WEIGHT_LEN-1:0] pos;
		logic [WEIGHT_LEN-1:0] w;
		logic [WEIGHT_LEN-1:0] h;
		logic [WEIGHT_LEN-1:0] color1;
		logic [WEIGHT_LEN-1:0] color2;
	} weights_t;

	// one line of the history buffer
	typedef struct packed {
		bbox_t bbox;
		id_t   id;
	} hist_entry_t;

	// best match held by a PE
	typedef struct packed {
		logic                 found; // at least one entry scored
		logic [SCORE_LEN-1:0] score; // lowest so far
		id_t                  id;    // id of that entry
	} pe_result_t;

endpackage

`default_nettype wire

//--- oflow_mem_buffer.sv
// ping-pong history memory, registered read from one bank, write to the other
`timescale 1ns/1ns
`default_nettype none

module oflow_mem_buffer import oflow_pkg::*; #(
	parameter  int PE_NUM   = 4,
	localparam int SLOT_LEN = (PE_NUM > 1) ? $clog2(PE_NUM) : 1
) (
	input  logic                clk,
	input  logic                bank_i,     // write bank, reads use ~bank_i
	input  logic [ADDR_LEN-1:0] rd_addr_i,
	input  logic                wr_en_i,
	input  logic [ADDR_LEN-1:0] wr_addr_i,
	input  logic [SLOT_LEN-1:0] wr_slot_i,  // which PE slot to store
	input  bbox_t [PE_NUM-1:0]  bboxes_i,
	input  id_t [PE_NUM-1:0]    ids_i,
	output hist_entry_t         rd_entry_o
);

	// ------------------------------
	// storage, bank bit on top of the address
	// ------------------------------
	hist_entry_t mem [0:2*MAX_BBOXES_PER_FRAME-1];
	hist_entry_t wr_entry;

	// slot select for the write port
	assign wr_entry.bbox = bboxes_i[wr_slot_i];
	assign wr_entry.id   = ids_i[wr_slot_i];

	always_ff @(posedge clk) begin
		if (wr_en_i) mem[{bank_i, wr_addr_i}] <= wr_entry;
	end

	// data one cycle after address
	always_ff @(posedge clk) begin
		rd_entry_o <= mem[{~bank_i, rd_addr_i}];
	end

endmodule

`default_nettype wire

//--- oflow_pe.sv
// processing element: holds one box, scores history entries, keeps best match
`timescale 1ns/1ns
`default_nettype none

module oflow_pe import oflow_pkg::*; (
	input  logic        clk,
	input  logic        reset_i,
	input  logic        load_i,
	input  bbox_t       bbox_i,
	input  logic        clear_i,
	input  logic        cmp_en_i,   // entry_i valid
	input  hist_entry_t entry_i,
	input  weights_t    weights_i,
	output bbox_t       cur_bbox_o,
	output pe_result_t  result_o
);

	bbox_t                cur_bbox_q;
	logic                 found_q;
	logic [SCORE_LEN-1:0] score_q;
	id_t                  id_q;
	logic [COORD_LEN-1:0] d_x;
	logic [COORD_LEN-1:0] d_y;
	logic [COORD_LEN-1:0] d_w;
	logic [COORD_LEN-1:0] d_h;
	logic [COORD_LEN-1:0] d_c1;
	logic [COORD_LEN-1:0] d_c2;
	logic [SCORE_LEN-1:0] score;
	logic                 better;

	function automatic logic [COORD_LEN-1:0] abs_diff(
		input logic [COORD_LEN-1:0] a,
		input logic [COORD_LEN-1:0] b
	);
		return (a > b) ? (a - b) : (b - a);
	endfunction

	// ------------------------------
	// score
	// ------------------------------
	assign d_x  = abs_diff(cur_bbox_q.x, entry_i.bbox.x);
	assign d_y  = abs_diff(cur_bbox_q.y, entry_i.bbox.y);
	assign d_w  = abs_diff(cur_bbox_q.w, entry_i.bbox.w);
	assign d_h  = abs_diff(cur_bbox_q.h, entry_i.bbox.h);
	assign d_c1 = abs_diff(cur_bbox_q.color1, entry_i.bbox.color1);
	assign d_c2 = abs_diff(cur_bbox_q.color2, entry_i.bbox.color2);

	// max 6 * 255 * 15, no overflow in 16 bits
	assign score = SCORE_LEN'(weights_i.pos) * SCORE_LEN'(d_x)
		+ SCORE_LEN'(weights_i.pos) * SCORE_LEN'(d_y)
		+ SCORE_LEN'(weights_i.w) * SCORE_LEN'(d_w)
		+ SCORE_LEN'(weights_i.h) * SCORE_LEN'(d_h)
		+ SCORE_LEN'(weights_i.color1) * SCORE_LEN'(d_c1)
		+ SCORE_LEN'(weights_i.color2) * SCORE_LEN'(d_c2);

	// strict compare, so on a tie the lower address stays
	assign better = !found_q || (score < score_q);

	// ------------------------------
	// registers
	// ------------------------------
	always_ff @(posedge clk) begin
		if (load_i) cur_bbox_q <= bbox_i;
	end

	always_ff @(posedge clk) begin
		if (reset_i || clear_i) found_q <= 1'b0;
		else if (cmp_en_i && better) found_q <= 1'b1;
	end

	always_ff @(posedge clk) begin
		if (cmp_en_i && better) begin
			score_q <= score;
			id_q    <= entry_i.id;
		end
	end

	assign cur_bbox_o     = cur_bbox_q;
	assign result_o.found = found_q;
	assign result_o.score = score_q;
	assign result_o.id    = id_q;

endmodule

`default_nettype wire

//--- oflow_id_alloc.sv
// id allocator: threshold match, fresh id counter, registered id outputs
`timescale 1ns/1ns
`default_nettype none

module oflow_id_alloc import oflow_pkg::*; #(
	parameter int PE_NUM = 4
) (
	input  logic                    clk,
	input  logic                    reset_i,
	input  logic                    alloc_i,
	input  logic [PE_NUM-1:0]       slot_mask_i,
	input  pe_result_t [PE_NUM-1:0] results_i,
	input  logic [SCORE_LEN-1:0]    score_th_i,
	output id_t [PE_NUM-1:0]        ids_o,
	output logic [PE_NUM-1:0]       ids_valid_o,
	output logic                    valid_id_o
);

	id_t              next_id_q; // next fresh id
	id_t              fresh;
	id_t [PE_NUM-1:0] ids_next;

	// matched slots reuse the stored id, the rest count up in slot order
	always_comb begin
		fresh    = next_id_q;
		ids_next = '0;
		for (int i = 0; i < PE_NUM; i++) begin
			if (slot_mask_i[i]) begin
				if (results_i[i].found && (results_i[i].score <= score_th_i)) begin
					ids_next[i] = results_i[i].id;
				end else begin
					ids_next[i] = fresh;
					fresh = fresh + 1'b1;
					if (fresh == '0) fresh = ID_LEN'(1); // skip id 0 on wrap
				end
			end
		end
	end

	always_ff @(posedge clk) begin
		if (reset_i) begin
			next_id_q   <= ID_LEN'(1);
			ids_valid_o <= '0;
			valid_id_o  <= 1'b0;
		end else begin
			valid_id_o <= alloc_i; // single pulse per set
			if (alloc_i) begin
				next_id_q   <= fresh;
				ids_valid_o <= slot_mask_i;
			end
		end
	end

	always_ff @(posedge clk) begin
		if (alloc_i) ids_o <= ids_next; // held through the write phase
	end

endmodule

`default_nettype wire

//--- oflow_core_fsm.sv
// frame and set control FSM, box counters, history read/write pointers, bank select
`timescale 1ns/1ns
`default_nettype none

module oflow_core_fsm import oflow_pkg::*; #(
	parameter  int PE_NUM   = 4,
	localparam int SLOT_LEN = (PE_NUM > 1) ? $clog2(PE_NUM) : 1
) (
	input  logic                     clk,
	input  logic                     reset_i,
	input  logic                     start_i,
	input  logic                     new_frame_i,
	input  logic [BBOX_CNT_LEN-1:0]  num_of_bbox_in_frame_i,
	input  logic                     new_set_from_dma_i,
	output logic                     ready_new_frame_o,
	output logic                     ready_new_set_o,
	output logic                     done_frame_o,
	output logic [FRAME_NUM_LEN-1:0] frame_num_o,
	output logic                     load_o,      // PEs latch the dma set
	output logic [PE_NUM-1:0]        slot_mask_o,
	output logic                     clear_o,
	output logic                     cmp_en_o,    // read strobe, one cycle late
	output logic [ADDR_LEN-1:0]      rd_addr_o,
	output logic                     alloc_o,
	output logic                     wr_en_o,
	output logic [ADDR_LEN-1:0]      wr_addr_o,
	output logic [SLOT_LEN-1:0]      wr_slot_o,
	output logic                     bank_o
);

	typedef enum logic [2:0] {
		ST_IDLE,
		ST_WAIT_FRAME,
		ST_WAIT_SET,
		ST_COMPARE,    // stream previous frame to the PEs
		ST_ALLOC,
		ST_WRITE,      // one slot per cycle into the write bank
		ST_END_SET
	} state_t;

	state_t                   state_q;
	logic [BBOX_CNT_LEN-1:0]  remain_q;     // boxes of this frame not yet loaded
	logic [BBOX_CNT_LEN-1:0]  set_cnt_q;    // boxes in current set
	logic [BBOX_CNT_LEN-1:0]  prev_count_q; // boxes in the read bank
	logic [BBOX_CNT_LEN-1:0]  rd_ptr_q;
	logic [BBOX_CNT_LEN-1:0]  wr_ptr_q;     // also counts boxes written this frame
	logic [SLOT_LEN-1:0]      wr_slot_q;
	logic                     bank_q;
	logic                     cmp_en_q;
	logic [FRAME_NUM_LEN-1:0] frame_num_q;
	logic [BBOX_CNT_LEN-1:0]  set_cnt_next;
	logic                     set_accept;
	logic                     rd_en;
	logic                     last_write;

	// ------------------------------
	// decode
	// ------------------------------
	assign set_accept   = (state_q == ST_WAIT_SET) && new_set_from_dma_i;
	assign set_cnt_next = (remain_q > BBOX_CNT_LEN'(PE_NUM)) ? BBOX_CNT_LEN'(PE_NUM) : remain_q;
	assign rd_en        = (state_q == ST_COMPARE) && (rd_ptr_q != prev_count_q);
	assign last_write   = BBOX_CNT_LEN'(wr_slot_q) == (set_cnt_q - 1'b1);

	always_comb begin
		for (int i = 0; i < PE_NUM; i++) begin
			slot_mask_o[i] = i < int'(set_cnt_q); // lowest set_cnt slots
		end
	end

	assign ready_new_frame_o = (state_q == ST_WAIT_FRAME);
	assign ready_new_set_o   = (state_q == ST_WAIT_SET);
	assign done_frame_o      = (state_q == ST_END_SET) && (remain_q == '0);
	assign frame_num_o       = frame_num_q;
	assign load_o            = set_accept;
	assign clear_o           = set_accept; // fresh search for every set
	assign cmp_en_o          = cmp_en_q;
	assign rd_addr_o         = rd_ptr_q[ADDR_LEN-1:0];
	assign alloc_o           = (state_q == ST_ALLOC);
	assign wr_en_o           = (state_q == ST_WRITE);
	assign wr_addr_o         = wr_ptr_q[ADDR_LEN-1:0];
	assign wr_slot_o         = wr_slot_q;
	assign bank_o            = bank_q;

	// ------------------------------
	// state and counters
	// ------------------------------
	always_ff @(posedge clk) begin
		if (reset_i) begin
			state_q      <= ST_IDLE;
			remain_q     <= '0;
			set_cnt_q    <= '0;
			prev_count_q <= '0;    // nothing to compare in first frame
			rd_ptr_q     <= '0;
			wr_ptr_q     <= '0;
			wr_slot_q    <= '0;
			bank_q       <= 1'b0;
			frame_num_q  <= '0;
		end else begin
			case (state_q)
				ST_IDLE: if (start_i) state_q <= ST_WAIT_FRAME;
				ST_WAIT_FRAME: if (new_frame_i) begin
					remain_q <= num_of_bbox_in_frame_i;
					wr_ptr_q <= '0;
					// empty frame closes at once
					state_q  <= (num_of_bbox_in_frame_i == '0) ? ST_END_SET : ST_WAIT_SET;
				end
				ST_WAIT_SET: if (new_set_from_dma_i) begin
					set_cnt_q <= set_cnt_next;
					remain_q  <= remain_q - set_cnt_next;
					rd_ptr_q  <= '0;
					state_q   <= ST_COMPARE;
				end
				ST_COMPARE: begin
					if (rd_en) rd_ptr_q <= rd_ptr_q + 1'b1;
					else state_q <= ST_ALLOC; // last entry lands in PEs this cycle
				end
				ST_ALLOC: begin
					wr_slot_q <= '0;
					state_q   <= ST_WRITE;
				end
				ST_WRITE: begin
					wr_ptr_q  <= wr_ptr_q + 1'b1;
					wr_slot_q <= wr_slot_q + 1'b1;
					if (last_write) state_q <= ST_END_SET;
				end
				ST_END_SET: begin
					if (remain_q == '0) begin
						bank_q       <= ~bank_q;     // this frame becomes previous
						frame_num_q  <= frame_num_q + 1'b1;
						prev_count_q <= wr_ptr_q;
						state_q      <= ST_WAIT_FRAME;
					end else begin
						state_q <= ST_WAIT_SET;
					end
				end
				default: state_q <= ST_IDLE;
			endcase
		end
	end

	// memory read latency is one cycle
	always_ff @(posedge clk) begin
		if (reset_i) cmp_en_q <= 1'b0;
		else cmp_en_q <= rd_en;
	end

endmodule

`default_nettype wire

//--- oflow_core.sv
// tracker core top: control FSM, PE array, id allocator and history buffer
`timescale 1ns/1ns
`default_nettype none

module oflow_core import oflow_pkg::*; #(
	parameter  int PE_NUM   = 4,
	localparam int SLOT_LEN = (PE_NUM > 1) ? $clog2(PE_NUM) : 1
) (
	input  logic                     clk,
	input  logic                     reset_i,
	input  logic                     start_i,
	input  logic                     new_frame_i,
	input  logic [BBOX_CNT_LEN-1:0]  num_of_bbox_in_frame_i,
	input  logic                     new_set_from_dma_i,
	input  bbox_t [PE_NUM-1:0]       set_of_bboxes_from_dma_i,
	input  weights_t                 weights_i,       // held as levels
	input  logic [SCORE_LEN-1:0]     score_th_i,      // match threshold
	output logic                     ready_new_frame_o,
	output logic                     ready_new_set_o,
	output logic                     valid_id_o,      // one cycle per set
	output id_t [PE_NUM-1:0]         ids_o,
	output logic [PE_NUM-1:0]        ids_valid_o,
	output logic                     done_frame_o,
	output logic [FRAME_NUM_LEN-1:0] frame_num_o
);

	// ------------------------------
	// wires
	// ------------------------------
	logic                load;       // set accepted
	logic                clear;      // best match back to not-found
	logic                cmp_en;     // history entry valid on rd_entry
	logic                alloc;
	logic                wr_en;
	logic                bank;       // write bank, reads use the other
	logic [PE_NUM-1:0]   slot_mask;  // valid slots of current set
	logic [ADDR_LEN-1:0] rd_addr;
	logic [ADDR_LEN-1:0] wr_addr;
	logic [SLOT_LEN-1:0] wr_slot;
	hist_entry_t         rd_entry;   // broadcast to all PEs
	bbox_t [PE_NUM-1:0]  cur_bboxes; // latched boxes, for write-back
	pe_result_t [PE_NUM-1:0] pe_results;

	// ------------------------------
	// control
	// ------------------------------
	oflow_core_fsm #(.PE_NUM(PE_NUM)) oflow_core_fsm_i (
		.clk                    (clk),
		.reset_i                (reset_i),
		.start_i                (start_i),
		.new_frame_i            (new_frame_i),
		.num_of_bbox_in_frame_i (num_of_bbox_in_frame_i),
		.new_set_from_dma_i     (new_set_from_dma_i),
		.ready_new_frame_o      (ready_new_frame_o),
		.ready_new_set_o        (ready_new_set_o),
		.done_frame_o           (done_frame_o),
		.frame_num_o            (frame_num_o),
		.load_o                 (load),
		.slot_mask_o            (slot_mask),
		.clear_o                (clear),
		.cmp_en_o               (cmp_en),
		.rd_addr_o              (rd_addr),
		.alloc_o                (alloc),
		.wr_en_o                (wr_en),
		.wr_addr_o              (wr_addr),
		.wr_slot_o              (wr_slot),
		.bank_o                 (bank)
	);

	// one PE per slot of the set
	for (genvar g = 0; g < PE_NUM; g++) begin : pe_gen
		oflow_pe oflow_pe_i (
			.clk        (clk),
			.reset_i    (reset_i),
			.load_i     (load),
			.bbox_i     (set_of_bboxes_from_dma_i[g]),
			.clear_i    (clear),
			.cmp_en_i   (cmp_en),
			.entry_i    (rd_entry),
			.weights_i  (weights_i),
			.cur_bbox_o (cur_bboxes[g]),
			.result_o   (pe_results[g])
		);
	end

	oflow_id_alloc #(.PE_NUM(PE_NUM)) oflow_id_alloc_i (
		.clk         (clk),
		.reset_i     (reset_i),
		.alloc_i     (alloc),
		.slot_mask_i (slot_mask),
		.results_i   (pe_results),
		.score_th_i  (score_th_i),
		.ids_o       (ids_o),
		.ids_valid_o (ids_valid_o),
		.valid_id_o  (valid_id_o)
	);

	oflow_mem_buffer #(.PE_NUM(PE_NUM)) oflow_mem_buffer_i (
		.clk        (clk),
		.bank_i     (bank),
		.rd_addr_i  (rd_addr),
		.wr_en_i    (wr_en),
		.wr_addr_i  (wr_addr),
		.wr_slot_i  (wr_slot),
		.bboxes_i   (cur_bboxes),
		.ids_i      (ids_o),      // registered ids, stable through write phase
		.rd_entry_o (rd_entry)
	);

endmodule

`default_nettype wire

//--- tb_oflow_checks.svh
// compare tasks for ids, slot masks, frame numbers, single-bit outputs and pulse counts
`ifndef TB_OFLOW_CHECKS_SVH
`define TB_OFLOW_CHECKS_SVH

	// ------------------------------
	// one task per kind of result
	// ------------------------------
	task automatic check_id(input string name, input id_t got, input id_t exp);
		check_cnt++;
		if (got !== exp) begin
			err_cnt++;
			$display("ERR %s got %h exp %h at %0t", name, got, exp, $time);
		end
	endtask

	task automatic check_mask(input string name, input logic [PE_NUM-1:0] got,
		input logic [PE_NUM-1:0] exp);
		check_cnt++;
		if (got !== exp) begin
			err_cnt++;
			$display("ERR %s got %h exp %h at %0t", name, got, exp, $time);
		end
	endtask

	task automatic check_frame_num(input string name, input logic [FRAME_NUM_LEN-1:0] got,
		input logic [FRAME_NUM_LEN-1:0] exp);
		check_cnt++;
		if (got !== exp) begin
			err_cnt++;
			$display("ERR %s got %h exp %h at %0t", name, got, exp, $time);
		end
	endtask

	// ready, valid and done levels
	task automatic check_bit(input string name, input logic got, input logic exp);
		check_cnt++;
		if (got !== exp) begin
			err_cnt++;
			$display("ERR %s got %h exp %h at %0t", name, got, exp, $time);
		end
	endtask

	task automatic check_count(input string name, input int got, input int exp);
		check_cnt++;
		if (got != exp) begin
			err_cnt++;
			$display("ERR %s got %h exp %h at %0t", name, got, exp, $time);
		end
	endtask

`endif

//--- tb_oflow_core.sv
// testbench for the tracker core: clock, reset, case reader, frame driver, summary
`timescale 1ns/1ns
`default_nettype none

module tb_oflow_core import oflow_pkg::*; ();

	localparam int PE_NUM         = 4;
	localparam int CLK_PERIOD     = 20;
	localparam int RESET_CYCLES   = 16;
	localparam int TIMEOUT_CYCLES = 200; // longest set is well below this
	localparam int QUIET_CYCLES   = 60;
	localparam int CASES_DEPTH    = 512;
	localparam int W_READY_FRAME  = 0;
	localparam int W_READY_SET    = 1;
	localparam int W_VALID_ID     = 2;
	localparam int W_DONE         = 3;

	logic                     clk;
	logic                     reset_i;
	logic                     start_i;
	logic                     new_frame_i;
	logic [BBOX_CNT_LEN-1:0]  num_of_bbox_in_frame_i;
	logic                     new_set_from_dma_i;
	bbox_t [PE_NUM-1:0]       set_of_bboxes_from_dma_i;
	weights_t                 weights_i;
	logic [SCORE_LEN-1:0]     score_th_i;
	logic                     ready_new_frame_o;
	logic                     ready_new_set_o;
	logic                     valid_id_o;
	id_t [PE_NUM-1:0]         ids_o;
	logic [PE_NUM-1:0]        ids_valid_o;
	logic                     done_frame_o;
	logic [FRAME_NUM_LEN-1:0] frame_num_o;

	logic [15:0] cases_mem [0:CASES_DEPTH-1]; // flat hex words from the cases file
	int          ptr         = 0;             // next word to read
	int          check_cnt   = 0;
	int          err_cnt     = 0;
	int          timeout_cnt = 0;
	int          frames_done = 0;
	int          done_cnt    = 0;             // done_frame_o pulses seen
	int          valid_cnt   = 0;             // valid_id_o pulses seen

	`include "tb_oflow_checks.svh"

	oflow_core #(.PE_NUM(PE_NUM)) oflow_core_i (.*);

	initial begin
		clk = 1'b0;
		forever #(CLK_PERIOD/2) clk = ~clk;
	end

	// pulse counters, outputs settle well before the falling edge
	always @(negedge clk) begin
		if (!reset_i && done_frame_o) done_cnt++;
		if (!reset_i && valid_id_o) valid_cnt++;
	end

	// ------------------------------
	// waits and case helpers
	// ------------------------------
	function automatic logic watched(input int which);
		case (which)
			W_READY_FRAME: return ready_new_frame_o;
			W_READY_SET:   return ready_new_set_o;
			W_VALID_ID:    return valid_id_o;
			default:       return done_frame_o;
		endcase
	endfunction

	task automatic wait_for(input int which, input string what, output bit ok);
		int n;
		n  = 0;
		ok = 1'b0;
		while (!ok && n < TIMEOUT_CYCLES) begin
			@(negedge clk);
			ok = watched(which);
			n++;
		end
		if (!ok) begin
			timeout_cnt++;
			$display("timeout, %s did not rise within %0d cycles", what, TIMEOUT_CYCLES);
		end
	endtask

	// six words from the cases file into one box
	function automatic bbox_t box_at(input int idx);
		bbox_t b;
		b.x      = cases_mem[idx][COORD_LEN-1:0];
		b.y      = cases_mem[idx+1][COORD_LEN-1:0];
		b.w      = cases_mem[idx+2][COORD_LEN-1:0];
		b.h      = cases_mem[idx+3][COORD_LEN-1:0];
		b.color1 = cases_mem[idx+4][COORD_LEN-1:0];
		b.color2 = cases_mem[idx+5][COORD_LEN-1:0];
		return b;
	endfunction

	// ------------------------------
	// one frame: header, sets, id checks, done
	// ------------------------------
	task automatic run_frame(output bit ok);
		int                count;
		int                remain;
		int                n_set;
		int                s;
		id_t               exp_ids [PE_NUM];
		logic [PE_NUM-1:0] exp_mask;
		count                = int'(cases_mem[ptr]);
		score_th_i           = cases_mem[ptr+1];
		weights_i.pos        = cases_mem[ptr+2][WEIGHT_LEN-1:0];
		weights_i.w          = cases_mem[ptr+3][WEIGHT_LEN-1:0];
		weights_i.h          = cases_mem[ptr+4][WEIGHT_LEN-1:0];
		weights_i.color1     = cases_mem[ptr+5][WEIGHT_LEN-1:0];
		weights_i.color2     = cases_mem[ptr+6][WEIGHT_LEN-1:0];
		ptr += 7;
		wait_for(W_READY_FRAME, "ready_new_frame_o", ok);
		if (!ok) return;
		new_frame_i            = 1'b1;
		num_of_bbox_in_frame_i = BBOX_CNT_LEN'(count);
		@(negedge clk);
		new_frame_i = 1'b0;
		remain      = count;
		while (remain > 0) begin
			n_set = (remain > PE_NUM) ? PE_NUM : remain; // last set may be short
			wait_for(W_READY_SET, "ready_new_set_o", ok);
			if (!ok) return;
			exp_mask = '0;
			for (s = 0; s < PE_NUM; s++) begin
				set_of_bboxes_from_dma_i[s] = '0; // unused slots stay zero
				exp_ids[s]                  = '0;
				if (s < n_set) begin
					set_of_bboxes_from_dma_i[s] = box_at(ptr);
					exp_ids[s]                  = cases_mem[ptr+6][ID_LEN-1:0];
					exp_mask[s]                 = 1'b1;
					ptr += 7;
				end
			end
			new_set_from_dma_i = 1'b1;
			@(negedge clk);
			new_set_from_dma_i = 1'b0;
			check_bit("ready_new_set_o", ready_new_set_o, 1'b0); // dropped after accept
			wait_for(W_VALID_ID, "valid_id_o", ok);
			if (!ok) return;
			for (s = 0; s < n_set; s++) begin
				check_id($sformatf("ids_o[%0d]", s), ids_o[s], exp_ids[s]);
			end
			check_mask("ids_valid_o", ids_valid_o, exp_mask);
			remain -= n_set;
		end
		wait_for(W_DONE, "done_frame_o", ok);
		if (!ok) return;
		@(negedge clk);
		frames_done++;
		check_bit("done_frame_o", done_frame_o, 1'b0); // single cycle pulse
		check_frame_num("frame_num_o", frame_num_o, FRAME_NUM_LEN'(frames_done));
		check_count("done_frame_o pulses", done_cnt, frames_done);
		check_bit("ready_new_frame_o", ready_new_frame_o, 1'b1);
	endtask

	// ------------------------------
	// main sequence
	// ------------------------------
	initial begin
		bit ok;
		int valid_before;
		reset_i                  = 1'b1;
		start_i                  = 1'b0;
		new_frame_i              = 1'b0;
		num_of_bbox_in_frame_i   = '0;
		new_set_from_dma_i       = 1'b0;
		set_of_bboxes_from_dma_i = '0;
		weights_i                = '0;
		score_th_i               = '0;
		$readmemh("oflow_cases.txt", cases_mem);
		repeat (RESET_CYCLES) @(negedge clk);
		reset_i = 1'b0;
		@(negedge clk);
		check_bit("ready_new_frame_o", ready_new_frame_o, 1'b0);
		check_bit("ready_new_set_o", ready_new_set_o, 1'b0);
		check_bit("valid_id_o", valid_id_o, 1'b0);
		check_bit("done_frame_o", done_frame_o, 1'b0);
		check_frame_num("frame_num_o", frame_num_o, '0);
		start_i = 1'b1;
		@(negedge clk);
		start_i = 1'b0;
		check_bit("ready_new_frame_o", ready_new_frame_o, 1'b1); // one cycle after start
		ok = 1'b1;
		// box count 0 ends the list
		while (ok && ptr < CASES_DEPTH && !$isunknown(cases_mem[ptr]) && cases_mem[ptr] != 0) begin
			run_frame(ok);
		end
		if (ok && (ptr >= CASES_DEPTH || $isunknown(cases_mem[ptr]) || frames_done == 0)) begin
			err_cnt++;
			$display("cases file is missing, empty or has no end marker");
		end
		// stray set strobe while only a frame is expected
		if (ok) begin
			valid_before       = valid_cnt;
			new_set_from_dma_i = 1'b1;
			@(negedge clk);
			new_set_from_dma_i = 1'b0;
			repeat (QUIET_CYCLES) @(negedge clk);
			check_count("valid_id_o pulses", valid_cnt - valid_before, 0);
			check_bit("ready_new_set_o", ready_new_set_o, 1'b0);
			check_bit("ready_new_frame_o", ready_new_frame_o, 1'b1);
		end
		$display("frames %0d checks %0d errors %0d timeouts %0d",
			frames_done, check_cnt, err_cnt, timeout_cnt);
		if (err_cnt == 0 && timeout_cnt == 0) begin
			$display("** PASS **");
		end else begin
			$display("** FAIL **");
		end
		$finish;
	end

endmodule

`default_nettype wire

//--- oflow_cases.txt
// frame record: box_count score_th w_pos w_w w_h w_color1 w_color2, all hex
// box record: x y w h color1 color2 expected_id, all hex, box_count 0 ends the list
// frame 1, six new boxes, ids 1..6 over two sets
0006 0010 1 1 1 1 1
10 10 08 08 20 30 01
40 10 08 08 20 30 02
70 10 08 08 20 30 03
a0 10 08 08 20 30 04
10 60 08 08 20 30 05
40 60 08 08 20 30 06
// frame 2, same boxes, score 0 keeps every id
0006 0010 1 1 1 1 1
10 10 08 08 20 30 01
40 10 08 08 20 30 02
70 10 08 08 20 30 03
a0 10 08 08 20 30 04
10 60 08 08 20 30 05
40 60 08 08 20 30 06
// frame 3, color1 weight 0, far box takes fresh id 7
0003 0010 1 1 1 0 1
10 10 08 08 ff 30 01
e0 e0 08 08 20 30 07
40 10 08 08 20 30 02
// frame 4, two identical new boxes, ids 8 and 9
0002 0010 1 1 1 1 1
80 c0 08 08 20 30 08
80 c0 08 08 20 30 09
// frame 5, tie goes to the lower address, far box gets id 0a
0002 0010 1 1 1 1 1
80 c0 08 08 20 30 08
f0 40 08 08 20 30 0a
// end of list
0000

//--- filelist.f
+incdir+.
oflow_pkg.sv
oflow_mem_buffer.sv
oflow_pe.sv
oflow_id_alloc.sv
oflow_core_fsm.sv
oflow_core.sv
tb_oflow_core.sv
